//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       ?= tb_ahb_burst_master
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "all tests passed"

clean:
	rm -rf $(OBJDIR)

//--- logic/ahb_burst_master.sv
`timescale 1ns/10ps
`default_nettype none

module ahb_burst_master #(
  parameter int QUEUE_DEPTH = 4
) (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              req,
  input  wire xfer_pkg::cmd_t    cmd,
  input  wire ahb_pkg::ahb_rsp_t bus_rsp,
  input  wire logic [31:0]       wdata,
  output logic                   req_ack,
  output ahb_pkg::ahb_req_t      bus_req,
  output logic                   wdata_take,
  output logic [31:0]            rdata,
  output logic                   rdata_valid,
  output logic                   done
);

  logic             q_valid;
  logic             q_ready;
  xfer_pkg::cmd_t   q_cmd;
  logic             b_valid;
  logic             b_ready;
  xfer_pkg::burst_t b_desc;

  cmd_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) queue0 (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .cmd     (cmd),
    .q_ready (q_ready),
    .req_ack (req_ack),
    .q_valid (q_valid),
    .q_cmd   (q_cmd)
  );

  burst_planner planner0 (
    .clk     (clk),
    .rst     (rst),
    .q_valid (q_valid),
    .q_cmd   (q_cmd),
    .b_ready (b_ready),
    .q_ready (q_ready),
    .b_valid (b_valid),
    .b_desc  (b_desc)
  );

  ahb_phase_engine engine0 (
    .clk         (clk),
    .rst         (rst),
    .b_valid     (b_valid),
    .b_desc      (b_desc),
    .bus_rsp     (bus_rsp),
    .wdata       (wdata),
    .b_ready     (b_ready),
    .bus_req     (bus_req),
    .wdata_take  (wdata_take),
    .rdata       (rdata),
    .rdata_valid (rdata_valid),
    .done        (done)
  );

endmodule

`default_nettype wire

//--- logic/ahb_phase_engine.sv
`timescale 1ns/10ps
`default_nettype none

module ahb_phase_engine (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              b_valid,
  input  wire xfer_pkg::burst_t  b_desc,
  input  wire ahb_pkg::ahb_rsp_t bus_rsp,
  input  wire logic [31:0]       wdata,
  output logic                   b_ready,
  output ahb_pkg::ahb_req_t      bus_req,
  output logic                   wdata_take,
  output logic [31:0]            rdata,
  output logic                   rdata_valid,
  output logic                   done
);

  xfer_pkg::phase_state_e state;
  logic                   hready;
  logic                   take;

  // beat currently in its address phase
  logic [31:0]      a_addr;
  logic             a_write;
  ahb_pkg::hburst_e a_burst;
  logic [4:0]       a_left;     // beats still to come after this one
  logic             a_first;
  logic             a_last_cmd;

  // beat currently in its data phase
  logic d_valid;
  logic d_write;
  logic d_end;

  assign hready = bus_rsp.hready;

  // a new burst may only replace the final address phase once it completes
  assign b_ready = (state != xfer_pkg::PH_ADDR) | ((a_left == 5'd0) & hready);
  assign take    = b_valid & b_ready;

  assign wdata_take = d_valid & d_write & hready;

  always_comb begin
    bus_req.haddr = a_addr;
    if (state != xfer_pkg::PH_ADDR) begin
      bus_req.htrans = ahb_pkg::IDLE;
    end else if (a_first) begin
      bus_req.htrans = ahb_pkg::NONSEQ;
    end else begin
      bus_req.htrans = ahb_pkg::SEQ;
    end
    bus_req.hwrite    = a_write;
    bus_req.hsize     = ahb_pkg::HSIZE_WORD;
    bus_req.hburst    = a_burst;
    bus_req.hprot     = 4'b0000;
    bus_req.hmastlock = 1'b0;
    bus_req.hwdata    = wdata; // host holds the word until wdata_take
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state       <= xfer_pkg::PH_IDLE;
      a_addr      <= '0;
      a_write     <= 1'b0;
      a_burst     <= ahb_pkg::SINGLE;
      a_left      <= '0;
      a_first     <= 1'b0;
      a_last_cmd  <= 1'b0;
      d_valid     <= 1'b0;
      d_write     <= 1'b0;
      d_end       <= 1'b0;
      done        <= 1'b0;
      rdata_valid <= 1'b0;
    end else begin
      done        <= d_valid & d_end & hready;
      rdata_valid <= d_valid & ~d_write & hready;

      // an address phase that completes moves into the data phase
      if (hready) begin
        d_valid <= (state == xfer_pkg::PH_ADDR);
        d_write <= a_write;
        d_end   <= a_last_cmd & (a_left == 5'd0);
      end

      if (take) begin
        state      <= xfer_pkg::PH_ADDR;
        a_addr     <= b_desc.addr;
        a_write    <= b_desc.write;
        a_burst    <= b_desc.hburst;
        a_left     <= b_desc.beats - 5'd1;
        a_first    <= 1'b1;
        a_last_cmd <= b_desc.last;
      end else begin
        case (state)
          xfer_pkg::PH_ADDR: begin
            if (hready) begin
              if (a_left != 5'd0) begin
                a_addr  <= a_addr + 32'd4;
                a_left  <= a_left - 5'd1;
                a_first <= 1'b0;
              end else begin
                state <= xfer_pkg::PH_LAST_DATA;
              end
            end
          end
          xfer_pkg::PH_LAST_DATA: begin
            if (hready) begin
              state <= xfer_pkg::PH_IDLE;
            end
          end
          default: begin
            state <= xfer_pkg::PH_IDLE;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (d_valid && !d_write && hready) begin
      rdata <= bus_rsp.hrdata;
    end
  end

endmodule

`default_nettype wire

//--- logic/ahb_pkg.sv
`default_nettype none

package ahb_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // only word transfers are issued by the master
  localparam logic [2:0] HSIZE_WORD = 3'b010;

  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR   = 3'b001,
    WRAP4  = 3'b010, // wrap codes are never driven by the master
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } hburst_e;

  typedef struct packed {
    logic [ADDR_W-1:0] haddr;
    htrans_e           htrans;
    logic              hwrite;
    logic [2:0]        hsize;
    hburst_e           hburst;
    logic [3:0]        hprot;
    logic              hmastlock;
    logic [DATA_W-1:0] hwdata;
  } ahb_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] hrdata;
    logic              hready;
    logic              hresp;
  } ahb_rsp_t;

endpackage

`default_nettype wire

//--- logic/burst_planner.sv
`timescale 1ns/10ps
`default_nettype none

module burst_planner (
  input  wire logic           clk,
  input  wire logic           rst,
  input  wire logic           q_valid,
  input  wire xfer_pkg::cmd_t q_cmd,
  input  wire logic           b_ready,
  output logic                q_ready,
  output logic                b_valid,
  output xfer_pkg::burst_t    b_desc
);

  xfer_pkg::plan_state_e state;
  logic [31:0]           cur_addr;
  logic [15:0]           remain;
  logic                  cur_write;
  logic [8:0]            room;
  logic [4:0]            beats;
  ahb_pkg::hburst_e      burst;
  logic                  last;
  logic                  b_fire;

  // words left before the next 1 KB boundary range from 1 to 256
  assign room = 9'd256 - {1'b0, cur_addr[9:2]};

  always_comb begin
    if (remain >= 16'd16 && room >= 9'd16) begin
      burst = ahb_pkg::INCR16;
      beats = 5'd16;
    end else if (remain >= 16'd8 && room >= 9'd8) begin
      burst = ahb_pkg::INCR8;
      beats = 5'd8;
    end else if (remain >= 16'd4 && room >= 9'd4) begin
      burst = ahb_pkg::INCR4;
      beats = 5'd4;
    end else begin
      burst = ahb_pkg::SINGLE;
      beats = 5'd1;
    end
  end

  assign last    = (remain == {11'd0, beats});
  assign b_valid = (state == xfer_pkg::PLAN_SPLIT);
  assign b_fire  = b_valid & b_ready;

  // the next command can be taken in the same cycle the last burst leaves
  assign q_ready = (state == xfer_pkg::PLAN_IDLE) | (b_fire & last);

  always_comb begin
    b_desc.addr   = cur_addr;
    b_desc.hburst = burst;
    b_desc.beats  = beats;
    b_desc.write  = cur_write;
    b_desc.last   = last;
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state     <= xfer_pkg::PLAN_IDLE;
      cur_addr  <= '0;
      remain    <= '0;
      cur_write <= 1'b0;
    end else begin
      if (q_valid && q_ready) begin
        state     <= xfer_pkg::PLAN_SPLIT;
        cur_addr  <= q_cmd.addr;
        remain    <= q_cmd.beats;
        cur_write <= q_cmd.write;
      end else if (b_fire) begin
        cur_addr <= cur_addr + {25'd0, beats, 2'b00}; // four bytes per beat
        remain   <= remain - {11'd0, beats};
        if (last) begin
          state <= xfer_pkg::PLAN_IDLE;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/cmd_queue.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  wire logic           clk,
  input  wire logic           rst,
  input  wire logic           req,
  input  wire xfer_pkg::cmd_t cmd,
  input  wire logic           q_ready,
  output logic                req_ack,
  output logic                q_valid,
  output xfer_pkg::cmd_t      q_cmd
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  xfer_pkg::cmd_t   mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_nxt;
  logic             push;
  logic             pop;

  assign push    = req & req_ack;
  assign pop     = q_valid & q_ready;
  assign q_valid = (count != '0);
  assign q_cmd   = mem[rd_ptr]; // oldest entry is always on the output

  always_comb begin
    count_nxt = count;
    if (push && !pop) begin
      count_nxt = count + 1'b1;
    end else if (pop && !push) begin
      count_nxt = count - 1'b1;
    end
  end

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      req_ack <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count   <= count_nxt;
      req_ack <= (count_nxt != CNT_W'(QUEUE_DEPTH)); // ack only with a free slot next cycle
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= cmd;
    end
  end

endmodule

`default_nettype wire

//--- logic/xfer_pkg.sv
`default_nettype none

package xfer_pkg;

  // one host command whose beat count is in words
  typedef struct packed {
    logic [31:0] addr;
    logic [15:0] beats;
    logic        write;
  } cmd_t;

  typedef struct packed {
    logic [31:0]      addr;
    ahb_pkg::hburst_e hburst;
    logic [4:0]       beats;  // 1, 4, 8 or 16
    logic             write;
    logic             last;   // final burst of its command
  } burst_t;

  typedef enum logic {
    PLAN_IDLE,
    PLAN_SPLIT
  } plan_state_e;

  // LAST_DATA means the address bus is idle and one data phase is still open
  typedef enum logic [1:0] {
    PH_IDLE,
    PH_ADDR,
    PH_LAST_DATA
  } phase_state_e;

endpackage

`default_nettype wire

//--- sim.f
logic/ahb_pkg.sv
logic/xfer_pkg.sv
logic/cmd_queue.sv
logic/burst_planner.sv
logic/ahb_phase_engine.sv
logic/ahb_burst_master.sv
verif/ahb_mem_model.sv
verif/tb_ahb_burst_master.sv

//--- verif/ahb_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module ahb_mem_model (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire ahb_pkg::ahb_req_t bus_req,
  output ahb_pkg::ahb_rsp_t      bus_rsp
);

  logic [31:0] mem [4096];
  int          seed;
  logic [31:0] rnd;
  logic        ready;
  logic        d_act;    // a beat is in its data phase
  logic        d_write;
  logic [11:0] d_idx;

  initial begin
    seed = 32'h34b0b244;
    for (int i = 0; i < 4096; i++) begin
      mem[i] = 32'h5a000000 ^ (32'(i) * 32'h00010001);
    end
  end

  always_comb begin
    bus_rsp.hrdata = mem[d_idx];
    bus_rsp.hready = ready;
    bus_rsp.hresp  = 1'b0; // OKAY only
  end

  always @(posedge clk or negedge rst) begin
    if (!rst) begin
      ready   <= 1'b1;
      d_act   <= 1'b0;
      d_write <= 1'b0;
      d_idx   <= '0;
    end else begin
      rnd = $random(seed);
      ready <= (rnd[1:0] != 2'b00); // about one wait state in four
      if (ready) begin
        // NONSEQ and SEQ both have the upper htrans bit set
        d_act   <= bus_req.htrans[1];
        d_write <= bus_req.hwrite;
        d_idx   <= bus_req.haddr[13:2];
        if (d_act && d_write) begin
          mem[d_idx] <= bus_req.hwdata;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_ahb_burst_master.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ahb_burst_master;

  localparam int NCMD = 16;
  localparam int NWR  = 8;

  logic              clk;
  logic              rst;
  logic              req;
  xfer_pkg::cmd_t    cmd;
  ahb_pkg::ahb_rsp_t bus_rsp;
  logic [31:0]       wdata = '0;
  logic              req_ack;
  ahb_pkg::ahb_req_t bus_req;
  logic              wdata_take;
  logic [31:0]       rdata;
  logic              rdata_valid;
  logic              done;

  int          seed = 32'h34b0b244;
  logic [31:0] c_addr [NCMD];
  int          c_beats [NCMD];
  logic        c_wr [NCMD];
  int          cum [NCMD];
  logic [31:0] wr_word [321];
  logic [31:0] rd_exp [320];
  logic [31:0] shadow [4096];
  int          nw;
  int          nr;
  int          limit = 100000;
  int          cycles = 0;

  // reference state of the bus that advances on each completed address phase
  int               bus_idx;
  logic [31:0]      b_addr;
  int               b_remain;
  int               blen_left;
  logic             cur_wr;
  logic [31:0]      n_addr;
  int               n_rem;
  logic             exp_wr;
  int               exp_len;
  ahb_pkg::hburst_e exp_burst;
  logic             dp_valid;
  logic             dp_write;
  logic [31:0]      dp_addr;
  int               dp_cnt;
  int               wt_cnt;
  int               rd_cnt;
  int               done_cnt;
  logic             mc_pend;
  logic [11:0]      mc_idx;
  logic [31:0]      mc_word;
  logic             hold_chk;
  logic [31:0]      p_addr;
  logic [6:0]       p_ctrl;

  wire logic hready  = bus_rsp.hready;
  wire logic addr_go = hready && (bus_req.htrans != ahb_pkg::IDLE);
  wire logic nseq_go = addr_go && (bus_req.htrans == ahb_pkg::NONSEQ);
  wire logic seq_go  = addr_go && (bus_req.htrans == ahb_pkg::SEQ);
  wire logic [6:0] ctrl = {bus_req.htrans, bus_req.hwrite, bus_req.hsize[0], bus_req.hburst};

  ahb_burst_master #(.QUEUE_DEPTH(4)) dut0 (
    .clk(clk), .rst(rst), .req(req), .cmd(cmd), .bus_rsp(bus_rsp), .wdata(wdata),
    .req_ack(req_ack), .bus_req(bus_req), .wdata_take(wdata_take), .rdata(rdata),
    .rdata_valid(rdata_valid), .done(done)
  );

  ahb_mem_model mem0 (.clk(clk), .rst(rst), .bus_req(bus_req), .bus_rsp(bus_rsp));

  task automatic abort_run();
    $display("tests failed");
    $fatal(1);
  endtask

  // largest burst that fits the remaining beats and the 1 KB block
  function automatic int burst_len(input logic [31:0] a, input int rem);
    int room;
    room = 256 - int'(a[9:2]);
    if (rem >= 16 && room >= 16) return 16;
    if (rem >= 8 && room >= 8) return 8;
    if (rem >= 4 && room >= 4) return 4;
    return 1;
  endfunction

  always_comb begin
    n_addr  = (b_remain == 0) ? c_addr[bus_idx] : b_addr;
    n_rem   = (b_remain == 0) ? c_beats[bus_idx] : b_remain;
    exp_wr  = (b_remain == 0) ? c_wr[bus_idx] : cur_wr;
    exp_len = burst_len(n_addr, n_rem);
    case (exp_len)
      16:      exp_burst = ahb_pkg::INCR16;
      8:       exp_burst = ahb_pkg::INCR8;
      4:       exp_burst = ahb_pkg::INCR4;
      default: exp_burst = ahb_pkg::SINGLE;
    endcase
  end

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("run timed out before all commands completed");
      abort_run();
    end
  end

  always @(posedge clk or negedge rst) begin
    if (!rst) begin
      bus_idx   <= 0;
      b_addr    <= '0;
      b_remain  <= 0;
      blen_left <= 0;
      cur_wr    <= 1'b0;
      dp_valid  <= 1'b0;
      dp_write  <= 1'b0;
      dp_addr   <= '0;
      dp_cnt    <= 0;
      wt_cnt    <= 0;
      rd_cnt    <= 0;
      done_cnt  <= 0;
      mc_pend   <= 1'b0;
      mc_idx    <= '0;
      mc_word   <= '0;
      hold_chk  <= 1'b0;
      p_addr    <= '0;
      p_ctrl    <= '0;
      wdata     <= wr_word[0];
    end else begin
      if (nseq_go) begin
        b_addr    <= n_addr + 32'd4;
        b_remain  <= n_rem - 1;
        blen_left <= exp_len - 1;
        if (b_remain == 0) begin
          bus_idx <= bus_idx + 1;
          cur_wr  <= c_wr[bus_idx];
        end
      end else if (seq_go) begin
        b_addr    <= b_addr + 32'd4;
        b_remain  <= b_remain - 1;
        blen_left <= blen_left - 1;
      end
      if (hready) begin
        dp_valid <= addr_go;
        dp_write <= bus_req.hwrite;
        dp_addr  <= bus_req.haddr;
      end
      if (dp_valid && hready) dp_cnt <= dp_cnt + 1;
      hold_chk <= !hready && (bus_req.htrans != ahb_pkg::IDLE);
      p_addr   <= bus_req.haddr;
      p_ctrl   <= ctrl;
      mc_pend  <= wdata_take;
      if (wdata_take) begin
        wt_cnt  <= wt_cnt + 1;
        mc_idx  <= dp_addr[13:2];
        mc_word <= wr_word[wt_cnt];
        wdata   <= wr_word[wt_cnt + 1]; // next word for the next write beat
      end
      if (rdata_valid) rd_cnt <= rd_cnt + 1;
      if (done) done_cnt <= done_cnt + 1;
    end
  end

  a_reset: assert property (@(posedge clk) !rst |-> (!done && !rdata_valid && !wdata_take
                            && !req_ack && bus_req.htrans == ahb_pkg::IDLE))
    else begin
      $display("outputs were not idle during reset");
      abort_run();
    end
  a_burst: assert property (@(posedge clk) disable iff (!rst) nseq_go |->
                            bus_req.hburst == exp_burst)
    else begin
      $display("FAIL %0t hburst expected %0d actual %0d", $time, $sampled(exp_burst),
               $sampled(bus_req.hburst));
      abort_run();
    end
  a_addr: assert property (@(posedge clk) disable iff (!rst) addr_go |-> bus_req.haddr == n_addr)
    else begin
      $display("FAIL %0t haddr expected %h actual %h", $time, $sampled(n_addr),
               $sampled(bus_req.haddr));
      abort_run();
    end
  a_dir: assert property (@(posedge clk) disable iff (!rst) addr_go |-> bus_req.hwrite == exp_wr)
    else begin
      $display("FAIL %0t hwrite expected %b actual %b", $time, $sampled(exp_wr),
               $sampled(bus_req.hwrite));
      abort_run();
    end
  a_extra: assert property (@(posedge clk) disable iff (!rst) nseq_go |->
                            (b_remain != 0 || bus_idx < NCMD))
    else begin
      $display("a burst started with no command left");
      abort_run();
    end
  a_len_end: assert property (@(posedge clk) disable iff (!rst)
                              (nseq_go || (hready && !addr_go)) |-> blen_left == 0)
    else begin
      $display("a burst ended before its length was reached");
      abort_run();
    end
  a_len_more: assert property (@(posedge clk) disable iff (!rst) seq_go |-> blen_left != 0)
    else begin
      $display("a burst ran past its length");
      abort_run();
    end
  a_boundary: assert property (@(posedge clk) disable iff (!rst) seq_go |->
                               bus_req.haddr[9:0] != '0)
    else begin
      $display("a burst crossed a 1 KB boundary");
      abort_run();
    end
  a_hold_addr: assert property (@(posedge clk) disable iff (!rst) hold_chk |->
                                bus_req.haddr == p_addr)
    else begin
      $display("FAIL %0t haddr expected %h actual %h", $time, $sampled(p_addr),
               $sampled(bus_req.haddr));
      abort_run();
    end
  a_hold_ctrl: assert property (@(posedge clk) disable iff (!rst) hold_chk |-> ctrl == p_ctrl)
    else begin
      $display("FAIL %0t htrans/hwrite/hburst expected %h actual %h", $time, $sampled(p_ctrl),
               $sampled(ctrl));
      abort_run();
    end
  a_take: assert property (@(posedge clk) disable iff (!rst)
                           (dp_valid && dp_write && hready) == wdata_take)
    else begin
      $display("wdata_take did not match a completed write beat");
      abort_run();
    end
  a_wdata: assert property (@(posedge clk) disable iff (!rst) wdata_take |->
                            bus_req.hwdata == wr_word[wt_cnt])
    else begin
      $display("FAIL %0t hwdata expected %h actual %h", $time, $sampled(wr_word[wt_cnt]),
               $sampled(bus_req.hwdata));
      abort_run();
    end
  a_mem: assert property (@(posedge clk) disable iff (!rst) mc_pend |-> mem0.mem[mc_idx] == mc_word)
    else begin
      $display("FAIL %0t mem expected %h actual %h", $time, $sampled(mc_word),
               $sampled(mem0.mem[mc_idx]));
      abort_run();
    end
  a_rdata: assert property (@(posedge clk) disable iff (!rst) rdata_valid |->
                            (rd_cnt < nr && rdata == rd_exp[rd_cnt]))
    else begin
      $display("FAIL %0t rdata expected %h actual %h", $time, $sampled(rd_exp[rd_cnt]),
               $sampled(rdata));
      abort_run();
    end
  a_done: assert property (@(posedge clk) disable iff (!rst) done |->
                           (done_cnt < NCMD && dp_cnt == cum[done_cnt]))
    else begin
      $display("done pulsed out of order or for no command");
      abort_run();
    end

  initial begin
    logic [31:0] tmp;
    int          off;
    int          sum;
    rst = 1'b0;
    req = 1'b0;
    cmd = '0;
    nw  = 0;
    nr  = 0;
    sum = 0;
    for (int i = 0; i < NWR; i++) begin
      tmp = $random(seed);
      c_beats[i] = 1 + int'(tmp[7:0]) % 40;
      if (i % 2 == 0) begin
        off = 1024 - 4 * (1 + int'(tmp[10:8]) % 6); // just below a 1 KB boundary
      end else begin
        off = 4 * int'(tmp[19:12]);
      end
      c_addr[i] = 32'(i * 2048 + off);
      c_wr[i] = 1'b1;
      c_addr[i + NWR] = c_addr[i];
      c_beats[i + NWR] = c_beats[i];
      c_wr[i + NWR] = 1'b0;
      for (int k = 0; k < c_beats[i]; k++) begin
        tmp = $random(seed);
        wr_word[nw] = tmp;
        shadow[int'(c_addr[i][13:2]) + k] = tmp;
        nw++;
      end
    end
    for (int i = 0; i < NWR; i++) begin
      for (int k = 0; k < c_beats[i]; k++) begin
        rd_exp[nr] = shadow[int'(c_addr[i][13:2]) + k];
        nr++;
      end
    end
    for (int i = 0; i < NCMD; i++) begin
      sum += c_beats[i];
      cum[i] = sum;
    end
    limit = 20 * sum + 2000;
    repeat (10) @(posedge clk);
    rst <= 1'b1;
    for (int i = 0; i < NCMD; i++) begin
      @(posedge clk);
      req        <= 1'b1;
      cmd.addr   <= c_addr[i];
      cmd.beats  <= 16'(c_beats[i]);
      cmd.write  <= c_wr[i];
      do @(posedge clk); while (!req_ack); // taken on this edge
      req <= 1'b0;
    end
    wait (done_cnt == NCMD);
    repeat (4) @(posedge clk);
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire
